// File: logic/flash_ctrl_pkg.sv
/*
  Shared types and constants for the SPI NOR flash command controller.
  Imported by every RTL block and by the testbench.
*/

`default_nettype none

package flash_ctrl_pkg;

  // ##########################################################################
  // Basic payload types
  // ##########################################################################

  typedef logic [7:0]  byte_t;
  typedef logic [23:0] addr_t;
  // Data byte count, 0 to 256
  typedef logic [8:0]  count_t;

  // Supported commands, CMD_NONE when nothing is decoded
  typedef enum logic [2:0] {
    CMD_NONE,
    CMD_READ_ID,
    CMD_RDSR1,
    CMD_WREN,
    CMD_READ3,
    CMD_PP3
  } cmd_kind_t;

  // Data phase direction as seen from the controller
  typedef enum logic {
    DIR_READ,
    DIR_WRITE
  } dir_t;

  // ##########################################################################
  // Flash opcodes and sizes
  // ##########################################################################

  localparam byte_t OP_READ_ID = 8'h90;
  localparam byte_t OP_RDSR1   = 8'h05;
  localparam byte_t OP_WREN    = 8'h06;
  localparam byte_t OP_READ3   = 8'h03;
  localparam byte_t OP_PP3     = 8'h02;

  localparam int ADDR_BYTES  = 3;
  localparam int ID_BYTES    = 2;
  localparam int PAGE_BYTES  = 256;
  // SCK is clock/2, so 8 bits take 16 cycles
  localparam int BYTE_CYCLES = 16;
  localparam int BYTE_CYC_W  = $clog2(BYTE_CYCLES);

endpackage

`default_nettype wire

// File: logic/flash_op_if.sv
/*
  Decoded command handed from the request decoder to the sequencer.
  Payload holds steady from start until busy drops.
*/

`timescale 1ns/1ns
`default_nettype none

interface flash_op_if;
  import flash_ctrl_pkg::*;

  // One-cycle launch pulse
  logic      start;
  cmd_kind_t kind;
  byte_t     opcode;
  // Address bytes to send, 0 or 3
  logic [1:0] addr_len;
  addr_t     address;
  count_t    data_len;
  dir_t      dir;
  // Sequencer owns this level
  logic      busy;

  modport source (output start, kind, opcode, addr_len, address, data_len, dir,
                  input busy);
  modport sink   (input start, kind, opcode, addr_len, address, data_len, dir,
                  output busy);

endinterface

`default_nettype wire

// File: logic/spi_byte_if.sv
/*
  Byte-level link between the sequencer and the SPI shifter.
  The result block listens on the monitor modport.
*/

`timescale 1ns/1ns
`default_nettype none

interface spi_byte_if;
  import flash_ctrl_pkg::*;

  // Sequencer side
  logic  load;
  byte_t tx_byte;
  // Keep CS low after this byte
  logic  hold_cs;
  // Byte in flight belongs to the data phase
  logic  phase_data;

  // Shifter side
  logic  byte_done;
  byte_t rx_byte;
  logic  active;

  modport master  (output load, tx_byte, hold_cs, phase_data,
                   input byte_done, rx_byte, active);
  modport slave   (input load, tx_byte, hold_cs,
                   output byte_done, rx_byte, active);
  modport monitor (input byte_done, rx_byte, phase_data);

endinterface

`default_nettype wire

// File: logic/flash_cmd_decode.sv
/*
  Turns the level request inputs into one registered command description.
  Requests seen while the sequencer is busy are dropped.
*/

`timescale 1ns/1ns
`default_nettype none

module flash_cmd_decode (
  input  logic                    spi_master_done,
  input  logic                    reset_PP3_send_address_counter,
  input  logic                    read_id,
  input  logic                    rdsr1,
  input  logic                    wren,
  input  logic                    read3,
  input  logic                    pp3,
  input  flash_ctrl_pkg::addr_t   address,
  input  flash_ctrl_pkg::count_t  num_bytes,
  flash_op_if.source              op
);
  import flash_ctrl_pkg::*;

  logic       take;
  cmd_kind_t  kind_d;
  byte_t      opcode_d;
  logic [1:0] alen_d;
  addr_t      addr_d;
  count_t     len_d;
  dir_t       dir_d;
  count_t     len_clamped;

  // Accept only when idle and no launch already in flight
  assign take = (read_id | rdsr1 | wren | read3 | pp3) & ~op.busy & ~op.start;

  // Page limits, 1 to PAGE_BYTES
  assign len_clamped = (num_bytes == '0) ? count_t'(1) :
                       (num_bytes > count_t'(PAGE_BYTES)) ? count_t'(PAGE_BYTES) :
                       num_bytes;

  // Same priority as the old controller
  always_comb begin
    kind_d   = CMD_NONE;
    opcode_d = '0;
    alen_d   = '0;
    addr_d   = '0;
    len_d    = '0;
    dir_d    = DIR_READ;
    if (read_id) begin
      // Zero address then two ID bytes
      kind_d   = CMD_READ_ID;
      opcode_d = OP_READ_ID;
      alen_d   = 2'(ADDR_BYTES);
      len_d    = count_t'(ID_BYTES);
    end else if (rdsr1) begin
      kind_d   = CMD_RDSR1;
      opcode_d = OP_RDSR1;
      len_d    = count_t'(1);
    end else if (wren) begin
      // Opcode only
      kind_d   = CMD_WREN;
      opcode_d = OP_WREN;
    end else if (read3) begin
      kind_d   = CMD_READ3;
      opcode_d = OP_READ3;
      alen_d   = 2'(ADDR_BYTES);
      addr_d   = address;
      len_d    = len_clamped;
    end else if (pp3) begin
      kind_d   = CMD_PP3;
      opcode_d = OP_PP3;
      alen_d   = 2'(ADDR_BYTES);
      addr_d   = address;
      len_d    = len_clamped;
      dir_d    = DIR_WRITE;
    end
  end

  always_ff @(posedge spi_master_done or posedge reset_PP3_send_address_counter) begin
    if (reset_PP3_send_address_counter) begin
      op.start <= 1'b0;
      op.kind  <= CMD_NONE;
    end else begin
      op.start <= take;
      if (take) begin
        op.kind <= kind_d;
      end
    end
  end

  // Command payload, held until the next accepted request
  always_ff @(posedge spi_master_done) begin
    if (take) begin
      op.opcode   <= opcode_d;
      op.addr_len <= alen_d;
      op.address  <= addr_d;
      op.data_len <= len_d;
      op.dir      <= dir_d;
    end
  end

  // Handshake rule toward the sequencer
  a_start_idle : assert property (@(posedge spi_master_done)
    disable iff (reset_PP3_send_address_counter) op.start |-> !op.busy);

endmodule

`default_nettype wire

// File: logic/flash_seq_execute.sv
/*
  Command sequencer. Walks opcode, address and data phases one SPI byte at
  a time with one shared counter, and reloads the shifter on byte_done.
*/

`timescale 1ns/1ns
`default_nettype none

module flash_seq_execute (
  input  logic                       spi_master_done,
  input  logic                       reset_PP3_send_address_counter,
  input  flash_ctrl_pkg::byte_t      write_data,
  output logic                       write_taken,
  output logic                       cmd_end,
  output flash_ctrl_pkg::cmd_kind_t  kind,
  flash_op_if.sink                   op,
  spi_byte_if.master                 spi
);
  import flash_ctrl_pkg::*;

  // State names the next byte to load, ST_LAST waits for the final byte
  typedef enum logic [2:0] {ST_IDLE, ST_OPCODE, ST_ADDR, ST_DATA, ST_LAST} state_t;

  state_t state;
  count_t cnt;
  logic   kick;
  logic   final_byte;
  count_t addr_last;
  count_t data_last;

  assign addr_last = count_t'(op.addr_len) - count_t'(1);
  assign data_last = op.data_len - count_t'(1);

  // Is the byte about to be loaded the last one of the command
  always_comb begin
    case (state)
      ST_OPCODE: final_byte = (op.addr_len == '0) && (op.data_len == '0);
      ST_ADDR:   final_byte = (cnt == addr_last) && (op.data_len == '0);
      ST_DATA:   final_byte = (cnt == data_last);
      default:   final_byte = 1'b0;
    endcase
  end

  // Outgoing byte, address MSB first
  always_comb begin
    case (state)
      ST_OPCODE: spi.tx_byte = op.opcode;
      ST_ADDR: begin
        case (cnt[1:0])
          2'd0:    spi.tx_byte = op.address[23:16];
          2'd1:    spi.tx_byte = op.address[15:8];
          default: spi.tx_byte = op.address[7:0];
        endcase
      end
      // Dummy zeros clock in read data
      ST_DATA:   spi.tx_byte = (op.dir == DIR_WRITE) ? write_data : '0;
      default:   spi.tx_byte = '0;
    endcase
  end

  // First byte from kick, the rest chained on byte_done
  assign spi.load = kick | (spi.byte_done & (state != ST_LAST) & (state != ST_IDLE));
  assign spi.hold_cs = ~final_byte;
  assign write_taken = spi.load & (state == ST_DATA) & (op.dir == DIR_WRITE);
  assign cmd_end = spi.byte_done & (state == ST_LAST);
  assign op.busy = (state != ST_IDLE);
  assign kind = op.kind;

  always_ff @(posedge spi_master_done or posedge reset_PP3_send_address_counter) begin
    if (reset_PP3_send_address_counter) begin
      state          <= ST_IDLE;
      cnt            <= '0;
      kick           <= 1'b0;
      spi.phase_data <= 1'b0;
    end else begin
      kick <= 1'b0;
      if (state == ST_IDLE) begin
        if (op.start) begin
          state <= ST_OPCODE;
          cnt   <= '0;
          kick  <= 1'b1;
        end
      end else if (state == ST_LAST) begin
        if (spi.byte_done) begin
          state <= ST_IDLE;
        end
      end else if (spi.load) begin
        // Phase of the byte now in flight
        spi.phase_data <= (state == ST_DATA);
        cnt <= cnt + count_t'(1);
        if (final_byte) begin
          state <= ST_LAST;
        end else if (state == ST_OPCODE) begin
          state <= (op.addr_len != '0) ? ST_ADDR : ST_DATA;
          cnt   <= '0;
        end else if ((state == ST_ADDR) && (cnt == addr_last)) begin
          state <= ST_DATA;
          cnt   <= '0;
        end
      end
    end
  end

  // Shifter is only reloaded when free or finishing
  a_load_free : assert property (@(posedge spi_master_done)
    disable iff (reset_PP3_send_address_counter)
    (spi.load && spi.active) |-> spi.byte_done);

endmodule

`default_nettype wire

// File: logic/spi_byte_shifter.sv
/*
  SPI mode 0 byte engine, MSB first, SCK at half the clock.
  One byte takes BYTE_CYCLES cycles and CS stays low while hold_cs was set.
*/

`timescale 1ns/1ns
`default_nettype none

module spi_byte_shifter (
  input  logic       spi_master_done,
  input  logic       reset_PP3_send_address_counter,
  input  logic       flash_so,
  output logic       flash_sck,
  output logic       flash_cs_n,
  output logic       flash_si,
  spi_byte_if.slave  spi
);
  import flash_ctrl_pkg::*;

  logic [BYTE_CYC_W-1:0] cyc;
  logic                  active_q;
  logic                  hold_q;
  logic                  byte_end;
  byte_t                 tx_sh;
  byte_t                 rx_sh;

  // Last cycle of the byte, SCK is high here
  assign byte_end = active_q && (cyc == BYTE_CYC_W'(BYTE_CYCLES - 1));

  assign spi.byte_done = byte_end;
  assign spi.rx_byte   = rx_sh;
  assign spi.active    = active_q;
  assign flash_si      = active_q ? tx_sh[7] : 1'b0;

  // ##########################################################################
  // Control and pins
  // ##########################################################################

  always_ff @(posedge spi_master_done or posedge reset_PP3_send_address_counter) begin
    if (reset_PP3_send_address_counter) begin
      active_q   <= 1'b0;
      cyc        <= '0;
      hold_q     <= 1'b0;
      flash_sck  <= 1'b0;
      flash_cs_n <= 1'b1;
    end else if (spi.load) begin
      // New byte, SCK starts low for mode 0
      active_q   <= 1'b1;
      cyc        <= '0;
      hold_q     <= spi.hold_cs;
      flash_sck  <= 1'b0;
      flash_cs_n <= 1'b0;
    end else if (active_q) begin
      cyc       <= cyc + 1'b1;
      flash_sck <= ~flash_sck;
      if (byte_end) begin
        active_q <= 1'b0;
        if (!hold_q) begin
          flash_cs_n <= 1'b1;
        end
      end
    end
  end

  // ##########################################################################
  // Shift registers
  // ##########################################################################

  always_ff @(posedge spi_master_done) begin
    // SI moves on the falling SCK edge
    if (spi.load) begin
      tx_sh <= spi.tx_byte;
    end else if (active_q && flash_sck) begin
      tx_sh <= {tx_sh[6:0], 1'b0};
    end
    // SO sampled as SCK rises
    if (active_q && !flash_sck) begin
      rx_sh <= {rx_sh[6:0], flash_so};
    end
  end

  // Bus stays quiet while deselected
  a_sck_idle : assert property (@(posedge spi_master_done)
    disable iff (reset_PP3_send_address_counter) flash_cs_n |-> !flash_sck);

endmodule

`default_nettype wire

// File: logic/flash_result.sv
/*
  Collects returned bytes and the status register value, and turns the
  sequencer's end-of-command strobe into the done pulse.
*/

`timescale 1ns/1ns
`default_nettype none

module flash_result (
  input  logic                       spi_master_done,
  input  logic                       reset_PP3_send_address_counter,
  input  logic                       cmd_end,
  input  flash_ctrl_pkg::cmd_kind_t  kind,
  output flash_ctrl_pkg::byte_t      read_data,
  output flash_ctrl_pkg::byte_t      status,
  output logic                       read_valid,
  output logic                       done,
  spi_byte_if.monitor                spi
);
  import flash_ctrl_pkg::*;

  logic rd_kind;
  logic rx_take;

  // Commands that return data
  assign rd_kind = (kind == CMD_READ_ID) || (kind == CMD_RDSR1) || (kind == CMD_READ3);
  // Received data byte, not opcode or address
  assign rx_take = spi.byte_done && spi.phase_data && rd_kind;

  always_ff @(posedge spi_master_done or posedge reset_PP3_send_address_counter) begin
    if (reset_PP3_send_address_counter) begin
      read_valid <= 1'b0;
      done       <= 1'b0;
      status     <= '0;
    end else begin
      read_valid <= rx_take;
      done       <= cmd_end;
      // Last status seen
      if (rx_take && (kind == CMD_RDSR1)) begin
        status <= spi.rx_byte;
      end
    end
  end

  always_ff @(posedge spi_master_done) begin
    if (rx_take) begin
      read_data <= spi.rx_byte;
    end
  end

endmodule

`default_nettype wire

// File: logic/flash_ctrl_top.sv
/*
  Top of the SPI NOR flash command controller.
  Request pins in, SPI pins and read results out.
*/

`timescale 1ns/1ns
`default_nettype none

module flash_ctrl_top (
  input  logic                    spi_master_done,
  input  logic                    reset_PP3_send_address_counter,
  input  logic                    read_id,
  input  logic                    rdsr1,
  input  logic                    wren,
  input  logic                    read3,
  input  logic                    pp3,
  input  flash_ctrl_pkg::addr_t   address,
  input  flash_ctrl_pkg::count_t  num_bytes,
  input  flash_ctrl_pkg::byte_t   write_data,
  output logic                    write_taken,
  output flash_ctrl_pkg::byte_t   read_data,
  output logic                    read_valid,
  output flash_ctrl_pkg::byte_t   status,
  output logic                    done,
  output logic                    busy,
  output logic                    flash_sck,
  output logic                    flash_cs_n,
  output logic                    flash_si,
  input  logic                    flash_so
);
  import flash_ctrl_pkg::*;

  cmd_kind_t kind;
  logic      cmd_end;

  flash_op_if op_bus ();
  spi_byte_if spi_bus ();

  assign busy = op_bus.busy;

  // Request decode
  flash_cmd_decode flash_cmd_decode_i (
    .spi_master_done, .reset_PP3_send_address_counter,
    .read_id, .rdsr1, .wren, .read3, .pp3, .address, .num_bytes,
    .op (op_bus.source)
  );

  // Phase sequencer
  flash_seq_execute flash_seq_execute_i (
    .spi_master_done, .reset_PP3_send_address_counter,
    .write_data, .write_taken, .cmd_end, .kind,
    .op (op_bus.sink), .spi (spi_bus.master)
  );

  // SPI pins
  spi_byte_shifter spi_byte_shifter_i (
    .spi_master_done, .reset_PP3_send_address_counter,
    .flash_so, .flash_sck, .flash_cs_n, .flash_si,
    .spi (spi_bus.slave)
  );

  flash_result flash_result_i (
    .spi_master_done, .reset_PP3_send_address_counter,
    .cmd_end, .kind, .read_data, .status, .read_valid, .done,
    .spi (spi_bus.monitor)
  );

endmodule

`default_nettype wire

// File: tb/flash_ctrl_checker.sv
/*
  Watches the flash controller outputs, compares read bytes, pulse counts
  and status against what the testbench expects, and runs the timeout.
*/

`timescale 1ns/1ns
`default_nettype none

module flash_ctrl_checker #(
  parameter int ROWS = 1
) (
  input  logic                  spi_master_done,
  input  logic                  reset_PP3_send_address_counter,
  input  logic                  busy,
  input  logic                  done,
  input  logic                  read_valid,
  input  logic                  write_taken,
  input  logic                  flash_cs_n,
  input  logic                  flash_sck,
  input  flash_ctrl_pkg::byte_t read_data,
  input  flash_ctrl_pkg::byte_t status,
  output logic                  timed_out,
  output logic                  any_error
);
  import flash_ctrl_pkg::*;

  // Worst case per row is a full page plus overhead
  localparam int LIMIT = ROWS * (260 * BYTE_CYCLES + 50);

  // Updated by the monitor process
  int    cycles = 0;
  int    got_cnt = 0;
  int    done_cnt = 0;
  int    wr_cnt = 0;
  int    value_errs = 0;
  int    idx;

  // Updated by the test tasks
  byte_t     exp_mem [PAGE_BYTES];
  int        exp_n = 0;
  int        exp_wr = 0;
  logic      chk_stat = 1'b0;
  logic      exp_wel = 1'b0;
  int        got_base = 0;
  int        done_base = 0;
  int        wr_base = 0;
  int        err_base = 0;
  int        cur_no = 0;
  cmd_kind_t cur_kind = CMD_NONE;
  int        n_tests = 0;
  int        n_failed = 0;

  initial timed_out = 1'b0;

  assign any_error = (n_failed != 0) || (value_errs != 0);

  function automatic string kind_name(input cmd_kind_t k);
    case (k)
      CMD_READ_ID: return "READ_ID";
      CMD_RDSR1:   return "RDSR1";
      CMD_WREN:    return "WREN";
      CMD_READ3:   return "READ3";
      CMD_PP3:     return "PP3";
      default:     return "NONE";
    endcase
  endfunction

  // ##########################################################################
  // Monitor, sampled mid-cycle
  // ##########################################################################

  always @(negedge spi_master_done) begin
    if (!reset_PP3_send_address_counter) begin
      cycles = cycles + 1;
      if (read_valid) begin
        idx = got_cnt - got_base;
        if (idx >= exp_n) begin
          $display("** Error at %0t ns: unexpected read byte %02h in test %0d",
                   $time, read_data, cur_no);
          value_errs++;
        end else if (read_data !== exp_mem[idx]) begin
          $display("** Error at %0t ns: test %0d byte %0d is %02h, expected %02h",
                   $time, cur_no, idx, read_data, exp_mem[idx]);
          value_errs++;
        end
        got_cnt++;
      end
      if (done) begin
        done_cnt++;
      end
      if (write_taken) begin
        wr_cnt++;
      end
      // Mode 0 keeps SCK low while deselected
      if (flash_cs_n && flash_sck) begin
        $display("** Error at %0t ns: SCK high while chip select is high", $time);
        value_errs++;
      end
      if (cycles > LIMIT && !timed_out) begin
        $display("Timeout: the run did not finish within %0d clock cycles", LIMIT);
        timed_out = 1'b1;
      end
    end
  end

  // ##########################################################################
  // Test bookkeeping, called from the testbench
  // ##########################################################################

  task automatic check_reset_state();
    logic ok;
    ok = !busy && !done && !read_valid && flash_cs_n && !flash_sck;
    if (!ok) begin
      $display("** Error at %0t ns: outputs not idle after reset", $time);
      n_failed++;
    end
    n_tests++;
    $display("Test 0 reset state: %s", ok ? "pass" : "FAIL");
  endtask

  task automatic begin_test(input int no, input cmd_kind_t kind, input int n,
                            input int writes, input logic chk, input logic wel);
    cur_no    = no;
    cur_kind  = kind;
    exp_n     = n;
    exp_wr    = writes;
    chk_stat  = chk;
    exp_wel   = wel;
    got_base  = got_cnt;
    done_base = done_cnt;
    wr_base   = wr_cnt;
    err_base  = value_errs;
  endtask

  task automatic expect_byte(input int i, input byte_t b);
    exp_mem[i] = b;
  endtask

  task automatic end_test();
    logic ok;
    ok = (value_errs == err_base);
    if (got_cnt - got_base != exp_n) begin
      $display("** Error at %0t ns: %0d read bytes, expected %0d",
               $time, got_cnt - got_base, exp_n);
      ok = 1'b0;
    end
    if (done_cnt - done_base != 1) begin
      $display("** Error at %0t ns: %0d done pulses, expected 1", $time, done_cnt - done_base);
      ok = 1'b0;
    end
    if (wr_cnt - wr_base != exp_wr) begin
      $display("** Error at %0t ns: %0d write_taken pulses, expected %0d",
               $time, wr_cnt - wr_base, exp_wr);
      ok = 1'b0;
    end
    if (busy) begin
      $display("Controller still busy after the command ended");
      ok = 1'b0;
    end
    if (chk_stat && (status[1] !== exp_wel)) begin
      $display("** Error at %0t ns: status %02h, WEL expected %0b", $time, status, exp_wel);
      ok = 1'b0;
    end
    n_tests++;
    if (!ok) begin
      n_failed++;
    end
    $display("Test %0d %s: %s", cur_no, kind_name(cur_kind), ok ? "pass" : "FAIL");
  endtask

  task automatic report_counts();
    $display("Tests run %0d, failed %0d, value mismatches %0d", n_tests, n_failed, value_errs);
  endtask

endmodule

`default_nettype wire

// File: tb/flash_ctrl_tb.sv
/*
  Testbench for the SPI NOR flash controller. Holds a behavioral flash
  model and a stimulus table, and applies the rows one by one.
*/

`timescale 1ns/1ns
`default_nettype none

module flash_ctrl_tb;
  import flash_ctrl_pkg::*;

  localparam int ROWS = 10;
  localparam int WBUF = 16;
  localparam int SEED = 6395;
  // Where a row's expected read bytes come from
  localparam int EXP_NONE = 0;
  localparam int EXP_ID   = 1;
  localparam int EXP_STAT = 2;
  localparam int EXP_WBUF = 3;
  localparam int EXP_FILL = 4;

  logic   spi_master_done = 1'b0;
  logic   reset_PP3_send_address_counter;
  logic   read_id, rdsr1, wren, read3, pp3;
  addr_t  address;
  count_t num_bytes;
  byte_t  write_data;
  logic   write_taken, read_valid, done, busy;
  byte_t  read_data, status;
  logic   flash_sck, flash_cs_n, flash_si;
  logic   flash_so = 1'b0;
  logic   timed_out, any_error;

  // Stimulus table
  cmd_kind_t row_cmd [ROWS];
  addr_t     row_addr [ROWS];
  count_t    row_num [ROWS];
  int        row_exp [ROWS];
  logic      row_wel [ROWS];
  logic      row_dup [ROWS];
  byte_t     wbuf [WBUF];

  // Flash model state
  byte_t mem [PAGE_BYTES];
  byte_t mdl_sh = 8'h00;
  byte_t mdl_op = 8'h00;
  byte_t mdl_out;
  addr_t mdl_addr = '0;
  int    mdl_bits = 0;
  logic  mdl_wel = 1'b0;
  logic  cs_q = 1'b1;
  logic  sck_q = 1'b0;

  always #50 spi_master_done = ~spi_master_done;

  flash_ctrl_top flash_ctrl_top_i (.*);

  flash_ctrl_checker #(.ROWS(ROWS + 1)) flash_ctrl_checker_i (
    .spi_master_done, .reset_PP3_send_address_counter, .busy, .done, .read_valid,
    .write_taken, .flash_cs_n, .flash_sck, .read_data, .status, .timed_out, .any_error
  );

  // Power-up contents, a different value per address
  function automatic byte_t fill_byte(input int a);
    return byte_t'(a * 37 + 11);
  endfunction

  // ##########################################################################
  // Behavioral SPI NOR flash, mode 0
  // ##########################################################################

  // Byte the flash returns at position b of the command
  function automatic byte_t resp_byte(input int b);
    if (mdl_op == OP_RDSR1 && b >= 1) begin
      return {6'b0, mdl_wel, 1'b0};
    end else if (mdl_op == OP_READ_ID && b == 4) begin
      return 8'h01;
    end else if (mdl_op == OP_READ_ID && b == 5) begin
      return 8'h20;
    end else if (mdl_op == OP_READ3 && b >= 4) begin
      return mem[8'(int'(mdl_addr[7:0]) + b - 4)];
    end
    return 8'h00;
  endfunction

  always @(flash_sck or flash_cs_n) begin
    // Select starts a new command
    if (flash_cs_n === 1'b0 && cs_q !== 1'b0) begin
      mdl_bits = 0;
      mdl_op   = 8'h00;
    end
    // WEL changes once the command is complete
    if (flash_cs_n === 1'b1 && cs_q === 1'b0) begin
      if (mdl_op == OP_WREN && mdl_bits == 8) begin
        mdl_wel = 1'b1;
      end else if (mdl_op == OP_PP3 && mdl_bits >= 40) begin
        mdl_wel = 1'b0;
      end
    end
    // SI taken on rising SCK
    if (flash_sck === 1'b1 && sck_q !== 1'b1 && flash_cs_n === 1'b0) begin
      mdl_sh   = {mdl_sh[6:0], flash_si};
      mdl_bits = mdl_bits + 1;
      if (mdl_bits % 8 == 0) begin
        if (mdl_bits == 8) begin
          mdl_op = mdl_sh;
        end else if (mdl_bits <= 32) begin
          mdl_addr = {mdl_addr[15:0], mdl_sh};
        end else if (mdl_op == OP_PP3 && mdl_wel) begin
          // Program ignored without WEL
          mem[8'(int'(mdl_addr[7:0]) + mdl_bits / 8 - 5)] = mdl_sh;
        end
      end
    end
    // SO moves on falling SCK
    if (flash_sck === 1'b0 && sck_q === 1'b1) begin
      mdl_out  = resp_byte(mdl_bits / 8);
      flash_so = mdl_out[7 - (mdl_bits % 8)];
    end
    cs_q  = flash_cs_n;
    sck_q = flash_sck;
  end

  // ##########################################################################
  // Stimulus
  // ##########################################################################

  task automatic set_row(input int i, input cmd_kind_t cmd, input addr_t addr,
                         input count_t num, input int exp, input logic wel, input logic dup);
    row_cmd[i]  = cmd;
    row_addr[i] = addr;
    row_num[i]  = num;
    row_exp[i]  = exp;
    row_wel[i]  = wel;
    row_dup[i]  = dup;
  endtask

  task automatic load_table();
    set_row(0, CMD_RDSR1,   24'h000000, 9'd1, EXP_STAT, 1'b0, 1'b0);
    set_row(1, CMD_READ_ID, 24'h000000, 9'd1, EXP_ID,   1'b0, 1'b0);
    set_row(2, CMD_WREN,    24'h000000, 9'd1, EXP_NONE, 1'b0, 1'b0);
    set_row(3, CMD_RDSR1,   24'h000000, 9'd1, EXP_STAT, 1'b1, 1'b0);
    set_row(4, CMD_PP3,     24'h000040, 9'd8, EXP_NONE, 1'b0, 1'b0);
    set_row(5, CMD_READ3,   24'h000040, 9'd8, EXP_WBUF, 1'b0, 1'b0);
    set_row(6, CMD_RDSR1,   24'h000000, 9'd1, EXP_STAT, 1'b0, 1'b0);
    // PP3 with WEL clear, memory must stay as filled
    set_row(7, CMD_PP3,     24'h000080, 9'd4, EXP_NONE, 1'b0, 1'b0);
    set_row(8, CMD_READ3,   24'h000080, 9'd4, EXP_FILL, 1'b0, 1'b0);
    // Second pulse while busy
    set_row(9, CMD_READ3,   24'h000010, 9'd3, EXP_FILL, 1'b0, 1'b1);
  endtask

  function automatic byte_t exp_value(input int i, input int j);
    case (row_exp[i])
      EXP_ID:   return (j == 0) ? 8'h01 : 8'h20;
      EXP_STAT: return {6'b0, row_wel[i], 1'b0};
      EXP_WBUF: return wbuf[j];
      default:  return fill_byte(int'(row_addr[i][7:0]) + j);
    endcase
  endfunction

  task automatic drive_request(input cmd_kind_t cmd);
    read_id = (cmd == CMD_READ_ID);
    rdsr1   = (cmd == CMD_RDSR1);
    wren    = (cmd == CMD_WREN);
    read3   = (cmd == CMD_READ3);
    pp3     = (cmd == CMD_PP3);
  endtask

  // One-cycle request pulse, falling edge to falling edge
  task automatic send_request(input cmd_kind_t cmd, input addr_t addr, input count_t num);
    @(negedge spi_master_done);
    address    = addr;
    num_bytes  = num;
    write_data = wbuf[0];
    drive_request(cmd);
    @(negedge spi_master_done);
    drive_request(CMD_NONE);
  endtask

  // Next write byte goes out the cycle after write_taken
  task automatic wait_done();
    int   widx;
    logic taken;
    widx  = 0;
    taken = 1'b0;
    while (!done) begin
      @(negedge spi_master_done);
      if (taken) begin
        widx       = widx + 1;
        write_data = wbuf[widx % WBUF];
      end
      taken = write_taken;
    end
  endtask

  task automatic run_row(input int i);
    int n;
    case (row_exp[i])
      EXP_ID:   n = ID_BYTES;
      EXP_STAT: n = 1;
      EXP_NONE: n = 0;
      default:  n = int'(row_num[i]);
    endcase
    flash_ctrl_checker_i.begin_test(i + 1, row_cmd[i], n,
                                    (row_cmd[i] == CMD_PP3) ? int'(row_num[i]) : 0,
                                    row_exp[i] == EXP_STAT, row_wel[i]);
    for (int j = 0; j < n; j++) begin
      flash_ctrl_checker_i.expect_byte(j, exp_value(i, j));
    end
    send_request(row_cmd[i], row_addr[i], row_num[i]);
    if (row_dup[i]) begin
      repeat (5) @(negedge spi_master_done);
      send_request(row_cmd[i], row_addr[i], row_num[i] + 9'd2);
    end
    wait_done();
    // Quiet gap shows up any extra command
    repeat (4) @(negedge spi_master_done);
    flash_ctrl_checker_i.end_test();
  endtask

  initial begin
    void'($urandom(SEED));
    reset_PP3_send_address_counter = 1'b1;
    drive_request(CMD_NONE);
    address    = '0;
    num_bytes  = '0;
    write_data = '0;
    for (int a = 0; a < PAGE_BYTES; a++) begin
      mem[a] = fill_byte(a);
    end
    for (int k = 0; k < WBUF; k++) begin
      wbuf[k] = byte_t'($urandom());
    end
    load_table();
    repeat (4) @(posedge spi_master_done);
    @(negedge spi_master_done);
    reset_PP3_send_address_counter = 1'b0;
    @(negedge spi_master_done);
    flash_ctrl_checker_i.check_reset_state();
    for (int i = 0; i < ROWS; i++) begin
      run_row(i);
    end
    flash_ctrl_checker_i.report_counts();
    if (!any_error) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  always @(posedge timed_out) begin
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: flash_ctrl.f
logic/flash_ctrl_pkg.sv
logic/flash_op_if.sv
logic/spi_byte_if.sv
logic/flash_cmd_decode.sv
logic/flash_seq_execute.sv
logic/spi_byte_shifter.sv
logic/flash_result.sv
logic/flash_ctrl_top.sv
tb/flash_ctrl_checker.sv
tb/flash_ctrl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the flash controller testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module flash_ctrl_tb \
  -f flash_ctrl.f \
  -o flash_ctrl_sim

./obj_dir/flash_ctrl_sim | tee sim.log

if grep -q "Errors found" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation passed"
